/* hr_cfg.svh */
`ifndef HR_CFG_SVH
`define HR_CFG_SVH

// chip-select high time between operations, in clk_i cycles
`define HR_TCSH 4

// chip-select fall to first bus clock edge
`define HR_TPRE 4

// last bus clock edge to chip-select rise
`define HR_TPOST 4

// initial access latency in bus clocks
`define HR_TACC 6

// set when the device runs with doubled initial latency
`define HR_DOUBLE 1

// read timeout in bus clocks
`define HR_TRMAX 20

`define HR_CA_BYTES 6
`define HR_DATA_BYTES 4

`endif

/* hr_pkg.sv */
`default_nettype none

package hr_pkg;

	// bus phases of one operation
	typedef enum logic [2:0] {
		IDLE,
		PRE,
		CA,
		LATENCY,
		WRITE,
		READ,
		POST
	} hr_state_e;

	// command-address word, filled by field and shifted out by byte
	typedef union packed {
		struct packed {
			logic        rd;
			logic        reg_space;
			logic        linear;
			logic [28:0] addr_hi;
			logic [12:0] rsvd;
			logic [2:0]  addr_lo;
		} fld;
		logic [5:0][7:0] bytes;
	} hr_ca_u;

endpackage

`default_nettype wire

/* hr_if.sv */
`timescale 1ns/1ns
`default_nettype none

// one latched host request, held until the sequencer reports done
interface hr_req_if;
	logic           pending;
	hr_pkg::hr_ca_u ca;
	logic [31:0]    wdata;
	logic [3:0]     sel;
	logic           rd;
	logic           done;

	modport source  (output pending, ca, wdata, sel, rd, input done);
	modport sink    (input pending, rd, output done);
	modport monitor (input ca, wdata, sel);
endinterface

// bus phase and cycle count, with the read byte count coming back
interface hr_bus_if;
	hr_pkg::hr_state_e state;
	logic [5:0]        cnt;
	logic [2:0]        bytes_left;

	modport source  (output state, cnt, input bytes_left);
	modport monitor (input state, cnt);
	modport sink    (input state, output bytes_left);
endinterface

`default_nettype wire

/* hr_request.sv */
`timescale 1ns/1ns
`default_nettype none

module hr_request (
	input  logic        clk_i,
	input  logic        rst_i,
	input  logic        valid_i,
	input  logic        wren_i,
	input  logic [31:0] addr_i,
	input  logic [3:0]  sel_i,
	input  logic [31:0] data_i,
	output logic        ready_o,
	hr_req_if.source    req
);

	logic valid_q;
	logic valid_rise;
	logic accept;

	// the host has to drop valid_i between requests
	assign valid_rise = valid_i && !valid_q;
	assign accept = valid_rise && !req.pending;

	assign ready_o = !req.pending;
	assign req.rd = req.ca.fld.rd;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			valid_q <= 1'b0;
			req.pending <= 1'b0;
		end else begin
			valid_q <= valid_i;
			if (req.done) begin
				req.pending <= 1'b0;
			end else if (accept) begin
				req.pending <= 1'b1;
			end
		end
	end

	// memory space, linear burst, address split around the reserved bits
	always_ff @(posedge clk_i) begin
		if (accept) begin
			req.wdata <= data_i;
			req.sel <= sel_i;
			req.ca.fld.rd <= !wren_i;
			req.ca.fld.reg_space <= 1'b0;
			req.ca.fld.linear <= 1'b1;
			req.ca.fld.addr_hi <= addr_i[31:3];
			req.ca.fld.rsvd <= '0;
			req.ca.fld.addr_lo <= addr_i[2:0];
		end
	end

endmodule

`default_nettype wire

/* hr_sequencer.sv */
`timescale 1ns/1ns
`default_nettype none

`include "hr_cfg.svh"

module hr_sequencer (
	input  logic     clk_i,
	input  logic     rst_i,
	hr_req_if.sink   req,
	hr_bus_if.source bus,
	output logic     read_timeout_o
);

	// counts are in clk_i cycles, two per bus clock
	localparam logic [5:0] LAT_RD = 6'(2 * `HR_TACC * (`HR_DOUBLE + 1) - 2);
	localparam logic [5:0] RD_TOUT = 6'(2 * `HR_TRMAX - 2);

	logic [5:0] lat_cycles;
	logic       cnt_zero;
	logic       timeout_q;

	// read data comes back one cycle late, so a write waits one cycle less
	assign lat_cycles = req.rd ? LAT_RD : LAT_RD - 6'd1;

	assign cnt_zero = (bus.cnt == 6'd0);
	assign req.done = (bus.state == hr_pkg::POST) && cnt_zero;
	assign read_timeout_o = timeout_q;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			bus.state <= hr_pkg::IDLE;
			bus.cnt <= 6'(`HR_TCSH);
			timeout_q <= 1'b0;
		end else begin
			// every phase counts down, a phase change reloads below
			if (!cnt_zero) begin
				bus.cnt <= bus.cnt - 6'd1;
			end
			case (bus.state)
				hr_pkg::IDLE: begin
					if (cnt_zero && req.pending) begin
						bus.state <= hr_pkg::PRE;
						bus.cnt <= 6'(`HR_TPRE);
						timeout_q <= 1'b0;
					end
				end
				hr_pkg::PRE: begin
					if (cnt_zero) begin
						bus.state <= hr_pkg::CA;
						bus.cnt <= 6'(`HR_CA_BYTES - 1);
					end
				end
				hr_pkg::CA: begin
					if (cnt_zero) begin
						bus.state <= hr_pkg::LATENCY;
						bus.cnt <= lat_cycles;
					end
				end
				hr_pkg::LATENCY: begin
					if (cnt_zero && req.rd) begin
						bus.state <= hr_pkg::READ;
						bus.cnt <= RD_TOUT;
					end else if (cnt_zero) begin
						bus.state <= hr_pkg::WRITE;
						bus.cnt <= 6'(`HR_DATA_BYTES - 1);
					end
				end
				hr_pkg::WRITE: begin
					if (cnt_zero) begin
						bus.state <= hr_pkg::POST;
						bus.cnt <= 6'(`HR_TPOST);
					end
				end
				hr_pkg::READ: begin
					// timeout when the device stopped short of four strobed bytes
					if (cnt_zero || (bus.bytes_left == 3'd0)) begin
						bus.state <= hr_pkg::POST;
						bus.cnt <= 6'(`HR_TPOST);
						timeout_q <= cnt_zero && (bus.bytes_left != 3'd0);
					end
				end
				hr_pkg::POST: begin
					if (cnt_zero) begin
						bus.state <= hr_pkg::IDLE;
						bus.cnt <= 6'(`HR_TCSH);
					end
				end
				default: begin
					bus.state <= hr_pkg::IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* hr_bus_drive.sv */
`timescale 1ns/1ns
`default_nettype none

module hr_bus_drive (
	input  logic       clk_i,
	input  logic       rst_i,
	hr_req_if.monitor  req,
	hr_bus_if.monitor  bus,
	output logic       hb_rstn_o,
	output logic       hb_csn_o,
	output logic       hb_clk_o,
	output logic       hb_clkn_o,
	output logic       hb_rwds_o,
	output logic       hb_rwds_oen_o,
	output logic [7:0] hb_dq_o,
	output logic [7:0] hb_dq_oen_o
);

	logic clk_q;
	logic clk_run;
	logic dq_en;
	logic rwds_en;

	assign clk_run = (bus.state == hr_pkg::CA) || (bus.state == hr_pkg::LATENCY) ||
		(bus.state == hr_pkg::WRITE) || (bus.state == hr_pkg::READ);

	// bus clock edges sit in the middle of the clk_i cycle that holds the data
	always_ff @(negedge clk_i) begin
		if (rst_i) begin
			clk_q <= 1'b0;
		end else begin
			clk_q <= clk_run ? !clk_q : 1'b0;
		end
	end

	assign dq_en = (bus.state == hr_pkg::CA) || (bus.state == hr_pkg::WRITE);
	assign rwds_en = (bus.state == hr_pkg::WRITE);

	// count runs down, so the most significant byte goes first
	always_comb begin
		case (bus.state)
			hr_pkg::CA:    hb_dq_o = req.ca.bytes[bus.cnt[2:0]];
			hr_pkg::WRITE: hb_dq_o = req.wdata[{bus.cnt[1:0], 3'b000} +: 8];
			default:       hb_dq_o = 8'h00;
		endcase
	end

	// rwds high masks the byte
	assign hb_rwds_o = rwds_en && !req.sel[bus.cnt[1:0]];
	assign hb_rwds_oen_o = !rwds_en;
	assign hb_dq_oen_o = {8{!dq_en}};

	assign hb_rstn_o = !rst_i;
	assign hb_csn_o = (bus.state == hr_pkg::IDLE);
	assign hb_clk_o = clk_q;
	assign hb_clkn_o = !clk_q;

endmodule

`default_nettype wire

/* hr_read_capture.sv */
`timescale 1ns/1ns
`default_nettype none

`include "hr_cfg.svh"

module hr_read_capture (
	input  logic        clk_i,
	input  logic        rst_i,
	input  logic        hb_rwds_i,
	input  logic [7:0]  hb_dq_i,
	hr_bus_if.sink      bus,
	output logic [31:0] data_o
);

	logic       rwds_q;
	logic       strobe;
	logic [1:0] slot;

	// odd bytes are qualified by the rwds level one cycle back
	assign strobe = bus.bytes_left[0] ? rwds_q : hb_rwds_i;

	// four bytes left lands in the top byte
	assign slot = 2'(bus.bytes_left - 3'd1);

	always_ff @(negedge clk_i) begin
		if (rst_i) begin
			bus.bytes_left <= 3'd0;
			rwds_q <= 1'b0;
			data_o <= '0;
		end else begin
			case (bus.state)
				hr_pkg::PRE: data_o <= '0;
				hr_pkg::CA:  bus.bytes_left <= 3'(`HR_DATA_BYTES);
				hr_pkg::READ: begin
					rwds_q <= hb_rwds_i;
					if (strobe && (bus.bytes_left != 3'd0)) begin
						bus.bytes_left <= bus.bytes_left - 3'd1;
						data_o[{slot, 3'b000} +: 8] <= hb_dq_i;
					end
				end
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

/* hr_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module hr_ctrl (
	input  logic        clk_i,
	input  logic        rst_i,
	input  logic        valid_i,
	input  logic        wren_i,
	input  logic [31:0] addr_i,
	input  logic [3:0]  sel_i,
	input  logic [31:0] data_i,
	output logic        ready_o,
	output logic [31:0] data_o,
	output logic        read_timeout_o,
	output logic        hb_rstn_o,
	output logic        hb_csn_o,
	output logic        hb_clk_o,
	output logic        hb_clkn_o,
	output logic        hb_rwds_o,
	output logic        hb_rwds_oen_o,
	output logic [7:0]  hb_dq_o,
	output logic [7:0]  hb_dq_oen_o,
	input  logic        hb_rwds_i,
	input  logic [7:0]  hb_dq_i
);

	hr_req_if req_if ();
	hr_bus_if bus_if ();

	// host side
	hr_request u_request (
		.clk_i   (clk_i),
		.rst_i   (rst_i),
		.valid_i (valid_i),
		.wren_i  (wren_i),
		.addr_i  (addr_i),
		.sel_i   (sel_i),
		.data_i  (data_i),
		.ready_o (ready_o),
		.req     (req_if.source)
	);

	hr_sequencer u_sequencer (
		.clk_i          (clk_i),
		.rst_i          (rst_i),
		.req            (req_if.sink),
		.bus            (bus_if.source),
		.read_timeout_o (read_timeout_o)
	);

	// device side
	hr_bus_drive u_bus_drive (
		.clk_i         (clk_i),
		.rst_i         (rst_i),
		.req           (req_if.monitor),
		.bus           (bus_if.monitor),
		.hb_rstn_o     (hb_rstn_o),
		.hb_csn_o      (hb_csn_o),
		.hb_clk_o      (hb_clk_o),
		.hb_clkn_o     (hb_clkn_o),
		.hb_rwds_o     (hb_rwds_o),
		.hb_rwds_oen_o (hb_rwds_oen_o),
		.hb_dq_o       (hb_dq_o),
		.hb_dq_oen_o   (hb_dq_oen_o)
	);

	hr_read_capture u_read_capture (
		.clk_i     (clk_i),
		.rst_i     (rst_i),
		.hb_rwds_i (hb_rwds_i),
		.hb_dq_i   (hb_dq_i),
		.bus       (bus_if.sink),
		.data_o    (data_o)
	);

endmodule

`default_nettype wire

/* hr_ctrl_assert.sv */
`timescale 1ns/1ns
`default_nettype none

module hr_ctrl_assert (
	input logic       clk_i,
	input logic       rst_i,
	input logic       ready_o,
	input logic       hb_csn_o,
	input logic       hb_clk_o,
	input logic       hb_rwds_oen_o,
	input logic [7:0] hb_dq_oen_o
);

	// deselected bus is released and its clock parked low
	idle_bus: assert property (@(posedge clk_i) disable iff (rst_i)
		hb_csn_o |-> (hb_dq_oen_o == 8'hff) && hb_rwds_oen_o && !hb_clk_o)
		else $error("bus driven or clocked while csn is high");

	busy_host: assert property (@(posedge clk_i) disable iff (rst_i)
		!hb_csn_o |-> !ready_o)
		else $error("ready_o high while csn is low");

	// rwds is only driven together with dq
	rwds_with_dq: assert property (@(posedge clk_i) disable iff (rst_i)
		hb_dq_oen_o[0] |-> hb_rwds_oen_o)
		else $error("rwds driven while dq is released");

endmodule

bind hr_ctrl hr_ctrl_assert u_assert (
	.clk_i         (clk_i),
	.rst_i         (rst_i),
	.ready_o       (ready_o),
	.hb_csn_o      (hb_csn_o),
	.hb_clk_o      (hb_clk_o),
	.hb_rwds_oen_o (hb_rwds_oen_o),
	.hb_dq_oen_o   (hb_dq_oen_o)
);

`default_nettype wire

/* hr_ctrl_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "hr_cfg.svh"

module hr_ctrl_tb;

	localparam int MAX_REQ = 16;

	// a write holds the latency phase for L+1 cycles, L one below the read value
	localparam int WR_LAT_CYCLES = 2 * `HR_TACC * (`HR_DOUBLE + 1) - 2;
	// one bus clock toggle per cycle of the command, latency and data phases
	localparam int WR_CLK_RISES = (`HR_CA_BYTES + WR_LAT_CYCLES + `HR_DATA_BYTES + 1) / 2;

	logic        clk_i;
	logic        rst_i;
	logic        valid_i;
	logic        wren_i;
	logic [31:0] addr_i;
	logic [3:0]  sel_i;
	logic [31:0] data_i;
	logic        ready_o;
	logic [31:0] data_o;
	logic        read_timeout_o;
	logic        hb_rstn_o;
	logic        hb_csn_o;
	logic        hb_clk_o;
	logic        hb_clkn_o;
	logic        hb_rwds_o;
	logic        hb_rwds_oen_o;
	logic [7:0]  hb_dq_o;
	logic [7:0]  hb_dq_oen_o;
	logic        hb_rwds_i;
	logic [7:0]  hb_dq_i;

	logic [31:0] stim_mem [0:5*MAX_REQ-1];
	int          n_req;
	logic        stim_ready;
	int          n_errors;
	int          n_checks;
	logic [31:0] lfsr_state;

	// bytes the device saw on the bus, over the whole run
	logic [7:0]  cap_dq [0:10*MAX_REQ-1];
	logic        cap_rwds [0:10*MAX_REQ-1];
	int          cap_total = 0;
	int          op_bytes = 0;
	event        ca_seen;

	// bus clock level at the last rising clk_i edge
	logic        clk_prev = 1'b0;
	int          clk_rises = 0;

	// read response of the current request
	logic [31:0] resp_data;
	logic [7:0]  resp_delay;

	int          csn_high_run = 0;
	int          min_gap = 1000;
	logic        seen_op = 1'b0;

	hr_ctrl dut_i (.*);

	initial clk_i = 1'b0;
	always #4 clk_i = ~clk_i;

	// 32-bit Galois LFSR with taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic [31:0] n;
		n = s >> 1;
		if (s[0]) begin
			n = n ^ 32'h8020_0003;
		end
		return n;
	endfunction

	function automatic logic [7:0] take_bits(input int count);
		logic [7:0] bits;
		int         k;
		bits = 8'h00;
		for (k = 0; k < count; k++) begin
			bits = {bits[6:0], lfsr_state[0]};
			lfsr_state = lfsr_step(lfsr_state);
		end
		return bits;
	endfunction

	// memory space, linear burst, address split around 13 reserved bits
	function automatic logic [47:0] ca_word(input logic rd, input logic [31:0] addr);
		return {rd, 1'b0, 1'b1, addr[31:3], 13'h0000, addr[2:0]};
	endfunction

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("Error at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic run_request(input int idx);
		logic        wr;
		logic [31:0] addr;
		logic [31:0] word;
		logic [3:0]  sel;
		logic [7:0]  delay;
		logic [47:0] ca_exp;
		int          base;
		int          rise_base;
		int          k;
		wr = stim_mem[5*idx][0];
		addr = stim_mem[5*idx+1];
		word = stim_mem[5*idx+2];
		sel = stim_mem[5*idx+3][3:0];
		delay = stim_mem[5*idx+4][7:0];
		ca_exp = ca_word(!wr, addr);
		repeat (int'(take_bits(3))) @(posedge clk_i);
		@(posedge clk_i);
		base = cap_total;
		rise_base = clk_rises;
		resp_data = word;
		resp_delay = wr ? 8'hff : delay;
		valid_i <= 1'b1;
		wren_i <= wr;
		addr_i <= addr;
		sel_i <= sel;
		data_i <= word;
		@(negedge clk_i);
		while (ready_o) @(negedge clk_i);
		@(posedge clk_i);
		valid_i <= 1'b0;
		@(negedge clk_i);
		while (!ready_o) @(negedge clk_i);
		check_value($sformatf("request %0d bus byte count", idx), 32'(cap_total - base),
			wr ? 32'd10 : 32'd6);
		for (k = 0; k < 6; k++) begin
			check_value($sformatf("request %0d command byte %0d", idx, k),
				32'(cap_dq[base+k]), 32'(ca_exp[47-8*k -: 8]));
		end
		if (wr) begin
			check_value($sformatf("request %0d bus clock rising edges", idx),
				32'(clk_rises - rise_base), 32'(WR_CLK_RISES));
			for (k = 0; k < 4; k++) begin
				check_value($sformatf("request %0d write byte %0d", idx, k),
					32'(cap_dq[base+6+k]), 32'(word[31-8*k -: 8]));
				check_value($sformatf("request %0d write mask %0d", idx, k),
					32'(cap_rwds[base+6+k]), 32'(!sel[3-k]));
			end
		end else begin
			check_value($sformatf("request %0d read data", idx), data_o,
				(delay == 8'hff) ? 32'h0 : word);
			check_value($sformatf("request %0d read timeout", idx), 32'(read_timeout_o),
				32'(delay == 8'hff));
		end
	endtask

	// device side records every byte the controller drives
	always @(negedge clk_i) begin
		if (hb_csn_o) begin
			op_bytes = 0;
		end else if (!hb_dq_oen_o[0] && cap_total < 10*MAX_REQ) begin
			check_value("hb_dq_oen_o while driving", 32'(hb_dq_oen_o), 32'h0);
			// rwds is driven only for the write data bytes
			check_value("hb_rwds_oen_o while driving", 32'(hb_rwds_oen_o),
				32'(op_bytes < 6));
			cap_dq[cap_total] = hb_dq_o;
			cap_rwds[cap_total] = hb_rwds_o;
			cap_total++;
			op_bytes++;
			// read flag is the top bit of the first command byte
			if (op_bytes == 6 && cap_dq[cap_total-6][7]) begin
				-> ca_seen;
			end
		end
	end

	// bus clock moves on falling clk_i edges, so it is looked at on rising ones
	always @(posedge clk_i) begin
		if (!rst_i) begin
			check_value("hb_clkn_o against hb_clk_o", 32'(hb_clkn_o), 32'(!hb_clk_o));
			if (hb_clk_o && !clk_prev) begin
				clk_rises++;
			end
		end
		clk_prev = hb_clk_o;
	end

	// delay counts rising edges after the last command byte
	initial begin : device_model
		int k;
		hb_rwds_i = 1'b0;
		hb_dq_i = 8'h00;
		forever begin
			@(ca_seen);
			if (resp_delay != 8'hff) begin
				repeat (int'(resp_delay)) @(posedge clk_i);
				for (k = 0; k < 4; k++) begin
					hb_rwds_i <= 1'b1;
					hb_dq_i <= resp_data[31-8*k -: 8];
					@(posedge clk_i);
				end
				hb_rwds_i <= 1'b0;
				hb_dq_i <= 8'h00;
			end
		end
	end

	// shortest chip-select high time between two operations
	always @(negedge clk_i) begin
		if (rst_i) begin
			csn_high_run = 0;
		end else if (hb_csn_o) begin
			csn_high_run++;
		end else begin
			if (seen_op && csn_high_run > 0 && csn_high_run < min_gap) begin
				min_gap = csn_high_run;
			end
			seen_op = 1'b1;
			csn_high_run = 0;
		end
	end

	initial begin : main
		int idx;
		rst_i = 1'b1;
		valid_i = 1'b0;
		wren_i = 1'b0;
		addr_i = 32'h0;
		sel_i = 4'h0;
		data_i = 32'h0;
		n_errors = 0;
		n_checks = 0;
		lfsr_state = 32'h426d_3d13;
		resp_data = 32'h0;
		resp_delay = 8'hff;
		stim_ready = 1'b0;
		$readmemh("hr_stim.txt", stim_mem);
		n_req = 0;
		while (n_req < MAX_REQ && stim_mem[5*n_req] != 32'hf) begin
			n_req++;
		end
		stim_ready = 1'b1;
		if (n_req == 0) begin
			n_errors++;
			$display("no requests found in hr_stim.txt");
		end
		repeat (2) @(posedge clk_i);
		check_value("hb_rstn_o during reset", 32'(hb_rstn_o), 32'd0);
		rst_i <= 1'b0;
		@(negedge clk_i);
		check_value("hb_rstn_o after reset", 32'(hb_rstn_o), 32'd1);
		check_value("csn after reset", 32'(hb_csn_o), 32'd1);
		check_value("hb_dq_oen_o after reset", 32'(hb_dq_oen_o), 32'hff);
		check_value("hb_rwds_oen_o after reset", 32'(hb_rwds_oen_o), 32'd1);
		check_value("ready_o after reset", 32'(ready_o), 32'd1);
		check_value("read_timeout_o after reset", 32'(read_timeout_o), 32'd0);
		check_value("data_o after reset", data_o, 32'h0);
		for (idx = 0; idx < n_req; idx++) begin
			run_request(idx);
		end
		if (n_req > 1) begin
			check_value($sformatf("csn high gap of %0d cycles reaches HR_TCSH", min_gap),
				32'(min_gap >= `HR_TCSH), 32'd1);
		end
		$display("%0d requests, %0d checks, %0d errors", n_req, n_checks, n_errors);
		if (n_errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

	initial begin : watchdog
		wait (stim_ready === 1'b1);
		repeat ((n_req + 1) * 200) @(posedge clk_i);
		$display("timeout: requests still running after %0d cycles", (n_req + 1) * 200);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

/* hr_stim.txt */
// op (1 write, 0 read, f end of list), address, data word, byte select, response delay
// delay counts clk_i rising edges after the last command byte, ff means no response
1 00000000 11223344 f 00
0 00000000 a5a55a5a f 18
1 00001238 deadbeef 5 00
0 00001238 cafef00d f 1e
0 0000fffc 01020304 f ff
1 12345677 89abcdef a 00
0 12345677 76543210 f 28
1 fffffff8 0f1e2d3c 3 00
0 fffffff8 c3d2e1f0 f 3a
0 00000040 5a5a5a5a f ff
1 80000001 00ff00ff 0 00
0 7ffffffc 13579bdf f 20
f 00000000 00000000 0 00

/* build.f */
+incdir+.
hr_pkg.sv
hr_if.sv
hr_request.sv
hr_sequencer.sv
hr_bus_drive.sv
hr_read_capture.sv
hr_ctrl.sv
hr_ctrl_assert.sv
hr_ctrl_tb.sv

/* run.sh */
#!/bin/sh
# build with Verilator, run, then scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module hr_ctrl_tb -f build.f -o hr_ctrl_sim

status=0
./obj_dir/hr_ctrl_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "FAIL: see errors above" sim.log; then
	echo "simulation failed"
	exit 1
fi
grep -q "PASS: all tests" sim.log
